// ==== src/datapathPkg.sv ====
package datapathPkg;

	typedef logic [31:0] word;     // bus and register width
	typedef logic [3:0]  regIndex; // general register number
	typedef logic [4:0]  opcode;   // instruction operation field

	// instruction field positions
	localparam int opHi    = 31;
	localparam int opLo    = 27;
	localparam int raHi    = 26;
	localparam int raLo    = 23;
	localparam int rbHi    = 22;
	localparam int rbLo    = 19;
	localparam int rcHi    = 18;
	localparam int rcLo    = 15;
	localparam int constHi = 18; // constant occupies bits constHi..0

	localparam int memWords = 512;

	// ALU functions share the opcode encoding
	typedef enum opcode {
		opAdd = 5'd3,
		opSub = 5'd4,
		opAnd = 5'd5,
		opOr  = 5'd6,
		opShr = 5'd7,
		opShl = 5'd8,
		opRor = 5'd9,
		opRol = 5'd10,
		opNeg = 5'd16,
		opNot = 5'd17
	} aluOp;

	// one cycle of strobes from the sequencer
	typedef struct packed {
		logic pcIn, irIn, marIn, mdrIn, yIn, zIn, rIn;
		logic pcOut, mdrOut, zOut, cOut, rOut, baOut;
		logic gra, grb, grc;
		logic read, write, incPc, clear;
		aluOp aluSel;
	} controlWord;

endpackage

// ==== src/registerFile.sv ====
`timescale 1ns/1ns

module registerFile (
	input  logic                Clock,
	input  logic                reset,
	input  logic                clear,
	input  datapathPkg::word    bus,
	input  logic [15:0]         regLoad,
	input  datapathPkg::regIndex regSel,
	input  logic                baseOut,
	output datapathPkg::word    readData
);

	datapathPkg::word regs [16];

	// every enabled register takes the bus in the same cycle
	always_ff @(posedge Clock) begin
		if (reset || clear) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int i = 0; i < 16; i++) begin
				if (regLoad[i]) begin
					regs[i] <= bus;
				end
			end
		end
	end

	// R0 acts as a zero base when used for base addressing
	always_comb begin
		if (baseOut && (regSel == 4'd0)) begin
			readData = '0;
		end else begin
			readData = regs[regSel];
		end
	end

endmodule

// ==== src/selectEncode.sv ====
`timescale 1ns/1ns

module selectEncode (
	input  datapathPkg::word     ir,
	input  logic                 gra,
	input  logic                 grb,
	input  logic                 grc,
	input  logic                 rIn,
	input  logic                 rOut,
	input  logic                 baOut,
	output logic [15:0]          regLoad,
	output datapathPkg::regIndex regSel,
	output logic                 regOutEnable,
	output logic                 baseOut,
	output datapathPkg::word     constant
);

	logic anySel;

	assign anySel = gra | grb | grc;

	// ra wins over rb, rb over rc
	always_comb begin
		if (gra) begin
			regSel = ir[datapathPkg::raHi:datapathPkg::raLo];
		end else if (grb) begin
			regSel = ir[datapathPkg::rbHi:datapathPkg::rbLo];
		end else if (grc) begin
			regSel = ir[datapathPkg::rcHi:datapathPkg::rcLo];
		end else begin
			regSel = '0;
		end

		regLoad = '0;
		if (rIn && anySel) regLoad[regSel] = 1'b1; // one-hot write enable
	end

	assign regOutEnable = rOut | baOut;
	assign baseOut      = baOut;
	assign constant     = {{(31 - datapathPkg::constHi){ir[datapathPkg::constHi]}},
		ir[datapathPkg::constHi:0]};

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ns

module alu (
	input  datapathPkg::word  y,
	input  datapathPkg::word  bus,
	input  datapathPkg::aluOp aluSel,
	input  logic              incPc,
	output datapathPkg::word  result
);

	logic [4:0]  amount;
	logic [63:0] rotRight;
	logic [63:0] rotLeft;

	assign amount = bus[4:0]; // only the low five bits set a shift

	// rotates come out of a doubled copy of Y
	assign rotRight = {y, y} >> amount;
	assign rotLeft  = {y, y} << amount;

	always_comb begin
		if (incPc) begin
			result = bus + 32'd1;
		end else begin
			case (aluSel)
				datapathPkg::opAdd: begin
					result = y + bus;
				end
				datapathPkg::opSub: begin
					result = y - bus;
				end
				datapathPkg::opAnd: begin
					result = y & bus;
				end
				datapathPkg::opOr: begin
					result = y | bus;
				end
				datapathPkg::opShr: begin
					result = y >> amount; // logical shift, zero fill
				end
				datapathPkg::opShl: begin
					result = y << amount;
				end
				datapathPkg::opRor: begin
					result = rotRight[31:0];
				end
				datapathPkg::opRol: begin
					result = rotLeft[63:32];
				end
				datapathPkg::opNeg: begin
					result = -bus;
				end
				datapathPkg::opNot: begin
					result = ~bus;
				end
				default: begin
					result = '0; // unused opcodes give zero
				end
			endcase
		end
	end

endmodule

// ==== src/memoryUnit.sv ====
`timescale 1ns/1ns

module memoryUnit #(
	parameter int depth = datapathPkg::memWords
) (
	input  logic             Clock,
	input  logic             reset,
	input  logic             clear,
	input  datapathPkg::word bus,
	input  datapathPkg::word memDataIn,
	input  logic             marIn,
	input  logic             mdrIn,
	input  logic             read,
	input  logic             write,
	output datapathPkg::word mdr
);

	localparam int addrBits = $clog2(depth);

	datapathPkg::word mar;
	datapathPkg::word mem [depth];
	logic [addrBits-1:0] address;

	assign address = mar[addrBits-1:0]; // upper MAR bits wrap

	always_ff @(posedge Clock) begin
		if (reset || clear) begin
			mar <= '0;
			mdr <= '0;
		end else begin
			if (marIn) mar <= bus;
			if (mdrIn) begin
				// without read the MDR is filled from outside
				mdr <= read ? mem[address] : memDataIn;
			end
		end
	end

	// contents survive reset and clear
	always_ff @(posedge Clock) begin
		if (write && !reset) begin
			mem[address] <= mdr;
		end
	end

endmodule

// ==== src/busMux.sv ====
`timescale 1ns/1ns

module busMux (
	input  datapathPkg::controlWord ctrl,
	input  logic                    regOutEnable,
	input  datapathPkg::word        pc,
	input  datapathPkg::word        mdr,
	input  datapathPkg::word        z,
	input  datapathPkg::word        regData,
	input  datapathPkg::word        constant,
	output datapathPkg::word        bus
);

	// the order only matters when more than one source is driven
	always_comb begin
		if (ctrl.pcOut) begin
			bus = pc;
		end else if (ctrl.mdrOut) begin
			bus = mdr;
		end else if (ctrl.zOut) begin
			bus = z;
		end else if (regOutEnable) begin
			bus = regData;
		end else if (ctrl.cOut) begin
			bus = constant;
		end else begin
			bus = '0; // idle bus reads as zero
		end
	end

endmodule

// ==== src/datapath.sv ====
`timescale 1ns/1ns

module datapath #(
	parameter int memWords = datapathPkg::memWords
) (
	input  logic                    Clock,
	input  logic                    reset,
	input  datapathPkg::controlWord ctrl,
	input  datapathPkg::word        memDataIn,
	output datapathPkg::word        bus
);

	datapathPkg::word pc, ir, y, z;
	datapathPkg::word mdr, regData, constant, aluResult;
	datapathPkg::regIndex regSel;
	logic [15:0] regLoad;
	logic regOutEnable, baseOut;

	always_ff @(posedge Clock) begin
		if (reset || ctrl.clear) begin
			pc <= '0;
			ir <= '0;
			y  <= '0;
			z  <= '0;
		end else begin
			if (ctrl.pcIn) pc <= bus;
			if (ctrl.irIn) ir <= bus;
			if (ctrl.yIn) y <= bus;
			if (ctrl.zIn) z <= aluResult; // ALU output is latched here only
		end
	end

	selectEncode encoder (
		.ir(ir), .gra(ctrl.gra), .grb(ctrl.grb), .grc(ctrl.grc),
		.rIn(ctrl.rIn), .rOut(ctrl.rOut), .baOut(ctrl.baOut),
		.regLoad(regLoad), .regSel(regSel), .regOutEnable(regOutEnable),
		.baseOut(baseOut), .constant(constant)
	);

	registerFile regFile (
		.Clock(Clock), .reset(reset), .clear(ctrl.clear), .bus(bus),
		.regLoad(regLoad), .regSel(regSel), .baseOut(baseOut), .readData(regData)
	);

	alu aluUnit (
		.y(y), .bus(bus), .aluSel(ctrl.aluSel), .incPc(ctrl.incPc), .result(aluResult)
	);

	memoryUnit #(.depth(memWords)) memory (
		.Clock(Clock), .reset(reset), .clear(ctrl.clear), .bus(bus),
		.memDataIn(memDataIn), .marIn(ctrl.marIn), .mdrIn(ctrl.mdrIn),
		.read(ctrl.read), .write(ctrl.write), .mdr(mdr)
	);

	busMux busSelect (
		.ctrl(ctrl), .regOutEnable(regOutEnable), .pc(pc), .mdr(mdr), .z(z),
		.regData(regData), .constant(constant), .bus(bus)
	);

endmodule

// ==== tests/datapath_chk.sv ====
`timescale 1ns/1ns

module datapathChk (
	input logic                    Clock,
	input logic                    reset,
	input datapathPkg::controlWord ctrl,
	input datapathPkg::word        bus,
	input logic [15:0]             regLoad
);

	logic [5:0] outStrobes;

	assign outStrobes = {ctrl.pcOut, ctrl.mdrOut, ctrl.zOut, ctrl.cOut, ctrl.rOut, ctrl.baOut};

	oneSource: assert property (@(posedge Clock) disable iff (reset) $onehot0(outStrobes))
		else $error("more than one bus source driven");

	idleBus: assert property (@(posedge Clock) disable iff (reset)
		(outStrobes == '0) |-> (bus == '0))
		else $error("bus not zero without a source");

	// a register write always needs rIn
	writeNeedsRin: assert property (@(posedge Clock) disable iff (reset)
		(regLoad != '0) |-> ctrl.rIn)
		else $error("register enable without rIn");

endmodule

bind datapath datapathChk chkInst (
	.Clock(Clock), .reset(reset), .ctrl(ctrl), .bus(bus), .regLoad(regLoad)
);

// ==== tests/datapathTb.sv ====
`timescale 1ns/1ns

module datapathTb;

	logic Clock;
	logic reset;
	datapathPkg::controlWord ctrl;
	datapathPkg::word memDataIn;
	datapathPkg::word busOut;

	logic [15:0] lfsrState = 16'd22028;
	int wordErrors = 0;
	int regErrors = 0;
	int otherErrors = 0;

	datapathPkg::word modelRegs [16];
	datapathPkg::word modelMem [512];
	datapathPkg::word modelPc;

	datapath #(.memWords(512)) UUT (
		.Clock(Clock), .reset(reset), .ctrl(ctrl), .memDataIn(memDataIn), .bus(busOut)
	);

	initial begin
		Clock = 1'b0;
		forever #20 Clock = ~Clock;
	end

	initial begin
		#2000000;
		$display("simulation ran past its time limit");
		$display("FAIL: see errors above");
		$finish;
	end

	// taps 16,14,13,11; one step per bit taken
	function automatic datapathPkg::word randBits(int n);
		datapathPkg::word value;
		logic fb;
		value = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
			lfsrState = {lfsrState[14:0], fb};
			value = {value[30:0], fb};
		end
		return value;
	endfunction

	function automatic datapathPkg::word aluModel(logic [4:0] op, datapathPkg::word a,
		datapathPkg::word b);
		logic [4:0] s;
		s = b[4:0];
		case (op)
			5'd3: return a + b;
			5'd4: return a - b;
			5'd5: return a & b;
			5'd6: return a | b;
			5'd7: return a >> s;
			5'd8: return a << s;
			5'd9: return (a >> s) | (a << (6'd32 - {1'b0, s}));
			5'd10: return (a << s) | (a >> (6'd32 - {1'b0, s}));
			5'd16: return ~b + 32'd1; // two's complement of the bus operand
			5'd17: return ~b;
			default: return '0;
		endcase
	endfunction

	task automatic checkWord(string name, datapathPkg::word expected, datapathPkg::word actual);
		if (expected !== actual) begin
			$display("Error %s expected %h actual %h", name, expected, actual);
			wordErrors++;
		end
	endtask

	task automatic checkReg(string name, datapathPkg::regIndex expected,
		datapathPkg::regIndex actual);
		if (expected !== actual) begin
			$display("Error %s expected %0d actual %0d", name, expected, actual);
			regErrors++;
		end
	endtask

	task automatic step(datapathPkg::controlWord cw, datapathPkg::word data);
		@(negedge Clock);
		ctrl = cw;
		memDataIn = data;
		@(posedge Clock);
	endtask

	// drive one word and look at the bus in the middle of the low phase
	task automatic probe(datapathPkg::controlWord cw, string name, datapathPkg::word expected);
		@(negedge Clock);
		ctrl = cw;
		#10;
		checkWord(name, expected, busOut);
		@(posedge Clock);
	endtask

	task automatic mdrLoad(datapathPkg::word data);
		datapathPkg::controlWord cw;
		cw = '0;
		cw.mdrIn = 1'b1;
		step(cw, data);
	endtask

	task automatic writeMem(datapathPkg::word addr, datapathPkg::word value);
		datapathPkg::controlWord cw;
		mdrLoad(addr);
		cw = '0;
		cw.mdrOut = 1'b1;
		cw.marIn = 1'b1;
		step(cw, '0);
		mdrLoad(value);
		cw = '0;
		cw.write = 1'b1;
		step(cw, '0);
		modelMem[addr[8:0]] = value;
	endtask

	task automatic setIr(datapathPkg::word value);
		datapathPkg::controlWord cw;
		mdrLoad(value);
		cw = '0;
		cw.mdrOut = 1'b1;
		cw.irIn = 1'b1;
		step(cw, '0);
	endtask

	task automatic loadReg(datapathPkg::regIndex idx, datapathPkg::word value);
		datapathPkg::controlWord cw;
		setIr({5'd0, idx, 23'd0});
		mdrLoad(value);
		cw = '0;
		cw.mdrOut = 1'b1;
		cw.gra = 1'b1;
		cw.rIn = 1'b1;
		step(cw, '0);
		modelRegs[idx] = value;
	endtask

	task automatic fetch();
		datapathPkg::controlWord cw;
		cw = '0;
		cw.pcOut = 1'b1;
		cw.marIn = 1'b1;
		cw.incPc = 1'b1;
		cw.zIn = 1'b1;
		step(cw, '0);
		cw = '0;
		cw.zOut = 1'b1;
		cw.pcIn = 1'b1;
		cw.read = 1'b1;
		cw.mdrIn = 1'b1;
		step(cw, '0);
		cw = '0;
		cw.mdrOut = 1'b1;
		cw.irIn = 1'b1;
		probe(cw, "fetch ir", modelMem[modelPc[8:0]]);
		modelPc = modelPc + 32'd1;
		cw = '0;
		cw.pcOut = 1'b1;
		probe(cw, "fetch pc", modelPc);
	endtask

	initial begin
		datapathPkg::controlWord cw;
		datapathPkg::word b;
		datapathPkg::word addr;
		datapathPkg::regIndex idx;
		logic [4:0] ops [11];
		int tries;
		ops = '{5'd3, 5'd4, 5'd5, 5'd6, 5'd7, 5'd8, 5'd9, 5'd10, 5'd16, 5'd17, 5'd20};
		ctrl = '0;
		memDataIn = '0;
		reset = 1'b1;
		modelPc = '0;
		repeat (8) @(posedge Clock);
		@(negedge Clock);
		reset = 1'b0;

		tries = 0;
		while (busOut !== '0 && tries < 4) begin
			@(negedge Clock);
			tries++;
		end
		if (busOut !== '0) begin
			$display("bus did not settle to zero after reset");
			otherErrors++;
		end
		cw = '0;
		cw.pcOut = 1'b1;
		probe(cw, "reset pc", '0);

		for (int i = 0; i < 4; i++) writeMem(i, randBits(32));
		for (int i = 0; i < 4; i++) fetch();

		for (int i = 0; i < 6; i++) begin
			idx = datapathPkg::regIndex'(randBits(4));
			loadReg(idx, randBits(32));
			cw = '0;
			cw.gra = 1'b1;
			cw.rOut = 1'b1;
			@(negedge Clock);
			ctrl = cw;
			#10;
			checkReg("register select", idx, UUT.regSel);
			checkWord("register readback", modelRegs[idx], busOut);
			@(posedge Clock);
		end
		loadReg(4'd0, randBits(32));
		cw = '0;
		cw.gra = 1'b1;
		cw.baOut = 1'b1;
		probe(cw, "base R0", '0);

		foreach (ops[k]) begin
			loadReg(4'd1, randBits(32));
			loadReg(4'd2, randBits(32));
			setIr({ops[k], 4'd0, 4'd1, 4'd2, 15'd0});
			cw = '0;
			cw.grb = 1'b1;
			cw.rOut = 1'b1;
			cw.yIn = 1'b1;
			step(cw, '0);
			cw = '0;
			cw.grc = 1'b1;
			cw.rOut = 1'b1;
			cw.zIn = 1'b1;
			cw.aluSel = datapathPkg::aluOp'(ops[k]);
			step(cw, '0);
			cw = '0;
			cw.zOut = 1'b1;
			probe(cw, $sformatf("alu op %0d", ops[k]), aluModel(ops[k], modelRegs[1],
				modelRegs[2]));
		end

		for (int i = 0; i < 4; i++) begin
			loadReg(4'd3, randBits(32));
			loadReg(4'd4, randBits(32));
			b = randBits(19);
			setIr({5'd2, 4'd3, 4'd4, b[18:0]});
			addr = modelRegs[4] + {{13{b[18]}}, b[18:0]};
			cw = '0;
			cw.grb = 1'b1;
			cw.rOut = 1'b1;
			cw.yIn = 1'b1;
			step(cw, '0);
			cw = '0;
			cw.cOut = 1'b1;
			cw.zIn = 1'b1;
			cw.aluSel = datapathPkg::opAdd;
			step(cw, '0);
			cw = '0;
			cw.zOut = 1'b1;
			cw.marIn = 1'b1;
			probe(cw, "store address", addr);
			mdrLoad(modelRegs[3]); // ra reaches the MDR through the external data port
			cw = '0;
			cw.write = 1'b1;
			step(cw, '0);
			modelMem[addr[8:0]] = modelRegs[3];
			mdrLoad(randBits(32));
			cw = '0;
			cw.read = 1'b1;
			cw.mdrIn = 1'b1;
			step(cw, '0);
			cw = '0;
			cw.mdrOut = 1'b1;
			probe(cw, "load back", modelMem[addr[8:0]]);
		end

		loadReg(4'd5, randBits(32));
		cw = '0;
		cw.clear = 1'b1;
		step(cw, '0);
		cw = '0;
		cw.pcOut = 1'b1;
		probe(cw, "clear pc", '0);
		cw = '0;
		cw.zOut = 1'b1;
		probe(cw, "clear z", '0);
		setIr({5'd0, 4'd5, 23'd0});
		cw = '0;
		cw.gra = 1'b1;
		cw.rOut = 1'b1;
		probe(cw, "clear register", '0);

		@(negedge Clock);
		ctrl = '0;
		$display("word errors %0d, register errors %0d, other errors %0d",
			wordErrors, regErrors, otherErrors);
		if (wordErrors + regErrors + otherErrors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
src/datapathPkg.sv
src/registerFile.sv
src/selectEncode.sv
src/alu.sv
src/memoryUnit.sv
src/busMux.sv
src/datapath.sv
tests/datapath_chk.sv
tests/datapathTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f flist.f --top-module datapathTb -o datapathSim &&
./obj_dir/datapathSim | tee /dev/stderr | grep -q "PASS: all tests" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
